// File: verilog.f
design/periph_pkg.sv
design/cpu_bus_if.sv
design/io_select_if.sv
design/io_address_decoder.sv
design/ems_page_mapper.sv
design/control_registers.sv
design/timer_clock_divider.sv
design/read_data_mux.sv
design/peripheral_glue_top.sv
verif/tb_peripheral_glue.sv

// File: Bender.yml
package:
  name: peripheral_glue

sources:
  - files:
      - design/periph_pkg.sv
      - design/cpu_bus_if.sv
      - design/io_select_if.sv
      - design/io_address_decoder.sv
      - design/ems_page_mapper.sv
      - design/control_registers.sv
      - design/timer_clock_divider.sv
      - design/read_data_mux.sv
      - design/peripheral_glue_top.sv
  - target: simulation
    files:
      - verif/tb_peripheral_glue.sv

// File: verif/tb_peripheral_glue.sv
/*
 * Peripheral glue testbench
 * Random bus traffic checked cycle by cycle against a reference model
 */
`timescale 1ns/1ns

module tb_peripheral_glue;
    import periph_pkg::*;

    localparam logic [15:0] EMS_BASE       = 16'h0260;
    localparam logic [15:0] LPT_BASE       = 16'h0378;
    localparam int          TIMEOUT_CYCLES = 6000;

    // Legacy slots take bits 0..4 of the select vector in address order
    localparam int SEL_PIC   = 1;
    localparam int SEL_PIT   = 2;
    localparam int SEL_PPI   = 3;
    localparam int SEL_EMS   = 5;
    localparam int SEL_LPT   = 6;
    localparam int SEL_NMI   = 7;
    localparam int SEL_VIDEO = 8;

    logic                 clock;
    logic                 reset;
    logic [ADDR_W-1:0]    address;
    logic [DATA_W-1:0]    write_data;
    logic                 io_read_n;
    logic                 io_write_n;
    logic                 memory_read_n;
    logic                 address_enable_n;
    logic                 interrupt_acknowledge_n;
    logic                 ems_enabled;
    logic [1:0]           ems_address;
    logic                 tandy_video;
    logic                 peripheral_clock;
    logic [DATA_W-1:0]    pic_data;
    logic [DATA_W-1:0]    pit_data;
    logic [DATA_W-1:0]    ppi_data;
    // Order matches the slot bits: DMA, PIC, PIT, PPI, DMA page
    logic [4:0]           cs_n;
    logic [EMS_BANKS-1:0] ems_bank_hit;
    logic [DATA_W-1:0]    lpt_data;
    logic [DATA_W-1:0]    nmi_mask;
    logic [DATA_W-1:0]    video_page;
    logic                 timer_clock;
    logic [DATA_W-1:0]    read_data;
    logic                 read_flag;

    // Reference model state
    logic [DATA_W-1:0]    model_lpt;
    logic [DATA_W-1:0]    model_nmi;
    logic [DATA_W-1:0]    model_video;
    logic [6:0]           model_page [4];
    logic [3:0]           model_en;
    logic                 pend_valid;
    logic [1:0]           pend_bank;
    logic [6:0]           pend_page;
    logic                 pend_enable;
    logic [8:0]           expected_read = '0;
    logic                 last_timer = 1'b0;
    int                   toggle_count = 0;
    int                   rise_count = 0;
    logic                 stop_peripheral_clock = 1'b0;

    peripheral_glue_top #(
        .EMS_PORT_BASE (EMS_BASE),
        .LPT_PORT_BASE (LPT_BASE)
    ) u_peripheral_glue_top (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .data_i                      (write_data),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .memory_read_n_i             (memory_read_n),
        .address_enable_n_i          (address_enable_n),
        .interrupt_acknowledge_n_i   (interrupt_acknowledge_n),
        .ems_enabled_i               (ems_enabled),
        .ems_address_i               (ems_address),
        .tandy_video_i               (tandy_video),
        .peripheral_clock_i          (peripheral_clock),
        .pic_data_i                  (pic_data),
        .pit_data_i                  (pit_data),
        .ppi_data_i                  (ppi_data),
        .dma_cs_n_o                  (cs_n[0]),
        .pic_cs_n_o                  (cs_n[1]),
        .pit_cs_n_o                  (cs_n[2]),
        .ppi_cs_n_o                  (cs_n[3]),
        .dma_page_cs_n_o             (cs_n[4]),
        .ems_bank_hit_o              (ems_bank_hit),
        .lpt_data_o                  (lpt_data),
        .nmi_mask_o                  (nmi_mask),
        .video_page_o                (video_page),
        .timer_clock_o               (timer_clock),
        .data_bus_out_o              (read_data),
        .data_bus_out_from_chipset_o (read_flag)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h",
                     $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Expected selects in slot order, then EMS, printer, NMI and video page
    function automatic logic [8:0] decode_selects(input logic [ADDR_W-1:0] addr,
                                                  input logic rd_n, input logic wr_n,
                                                  input logic aen_n, input logic ems_on,
                                                  input logic tandy);
        logic [8:0]  s;
        logic [15:0] p;
        s = '0;
        p = addr[15:0];
        if (!aen_n && (!rd_n || !wr_n)) begin
            if (addr[9:8] == 2'b00 && addr[7:5] <= 3'd4) begin
                s[addr[7:5]] = 1'b1;
            end
            s[SEL_EMS]   = ems_on && p >= EMS_BASE && p <= EMS_BASE + 16'd3;
            s[SEL_LPT]   = (p == LPT_BASE);
            s[SEL_NMI]   = tandy && p >= 16'h00A0 && p <= 16'h00A7;
            s[SEL_VIDEO] = (p == 16'h03DF);
        end
        return s;
    endfunction

    // Expected {flag, byte} on the read bus after the coming edge
    function automatic logic [8:0] ref_read(input logic [1:0] bank, input logic rd_n,
                                            input logic inta_n, input logic [8:0] s,
                                            input logic [7:0] pic, input logic [7:0] pit,
                                            input logic [7:0] ppi);
        if (!inta_n) begin
            return {1'b1, pic};
        end else if (rd_n) begin
            return 9'h000;
        end else if (s[SEL_PIC]) begin
            return {1'b1, pic};
        end else if (s[SEL_PIT]) begin
            return {1'b1, pit};
        end else if (s[SEL_PPI]) begin
            return {1'b1, ppi};
        end else if (s[SEL_EMS]) begin
            return {1'b1, model_en[bank] ? {1'b0, model_page[bank]} : 8'hFF};
        end else if (s[SEL_LPT]) begin
            return {1'b1, model_lpt};
        end else if (s[SEL_NMI]) begin
            return {1'b1, model_nmi};
        end
        return 9'h000;
    endfunction

    // Ports near the decoded ranges, with the odd fully random one
    function automatic logic [15:0] pick_port();
        case ($urandom_range(0, 5))
            0:       return 16'($urandom_range(0, 16'h00BF));
            1:       return 16'(EMS_BASE - 16'd1 + $urandom_range(0, 5));
            2:       return 16'(LPT_BASE - 16'd1 + $urandom_range(0, 2));
            3:       return 16'(16'h009F + $urandom_range(0, 9));
            4:       return 16'(16'h03DE + $urandom_range(0, 2));
            default: return 16'($urandom);
        endcase
    endfunction

    // One I/O cycle; strobe 0 is idle, 1 a read, 2 a write
    task automatic drive_cycle(input logic [15:0] port, input int strobe,
                               input logic [7:0] value);
        @(posedge clock);
        address          <= {4'h0, port};
        write_data       <= value;
        address_enable_n <= (strobe == 0);
        memory_read_n    <= 1'b1;
        io_read_n        <= (strobe != 1);
        io_write_n       <= (strobe != 2);
        pic_data         <= 8'($urandom);
        pit_data         <= 8'($urandom);
        ppi_data         <= 8'($urandom);
    endtask

    initial begin : clock_gen
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    initial begin : run_limit
        int cycle_count;
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Timeout: the run took more than %0d clock cycles", TIMEOUT_CYCLES);
                $display("test failed");
                $fatal(1, "run stopped at the cycle limit");
            end
        end
    end

    // Inputs and outputs are both settled at the falling edge
    always @(negedge clock) begin : compare_outputs
        logic [8:0] sel;
        logic [4:0] cs_exp;
        logic [3:0] hits;
        logic [3:0] nibble;
        if (reset) begin
            model_lpt   = 8'hFF;
            model_nmi   = 8'hFF;
            model_video = 8'h00;
            model_page  = '{default: '0};
            model_en    = '0;
            pend_valid  = 1'b0;
        end
        sel    = decode_selects(address, io_read_n, io_write_n, address_enable_n,
                                ems_enabled, tandy_video);
        cs_exp = ~sel[4:0];
        nibble = (ems_address == 2'd0) ? 4'hA : ((ems_address == 2'd1) ? 4'hC : 4'hD);
        for (int k = 0; k < 4; k++) begin
            hits[k] = io_read_n && io_write_n && model_en[k] &&
                      (address[19:14] == {nibble, 2'(k)});
        end
        check_value({read_flag, read_data}, expected_read, "read bus");
        check_value(cs_n, cs_exp, "chip selects");
        check_value(ems_bank_hit, hits, "EMS window hits");
        check_value(lpt_data, model_lpt, "printer latch");
        check_value(nmi_mask, model_nmi, "NMI mask");
        check_value(video_page, model_video, "video page");
        if (timer_clock !== last_timer) begin
            toggle_count++;
        end
        last_timer = timer_clock;
        // Step the model over the coming rising edge
        if (reset) begin
            expected_read = '0;
        end else begin
            expected_read = ref_read(address[1:0], io_read_n, interrupt_acknowledge_n, sel,
                                     pic_data, pit_data, ppi_data);
            if (pend_valid) begin
                model_page[pend_bank] = pend_page;
                model_en[pend_bank]   = pend_enable;
            end
            // EMS bytes 80h..FEh are ignored
            pend_valid  = !io_write_n && sel[SEL_EMS] &&
                          (write_data == 8'hFF || write_data < 8'h80);
            pend_bank   = address[1:0];
            pend_page   = (write_data == 8'hFF) ? 7'h7F : write_data[6:0];
            pend_enable = (write_data != 8'hFF);
            if (!io_write_n && sel[SEL_LPT]) begin
                model_lpt = write_data;
            end
            if (!io_write_n && sel[SEL_NMI]) begin
                model_nmi = write_data;
            end
            if (!io_write_n && sel[SEL_VIDEO]) begin
                model_video = write_data;
            end
        end
    end

    // Slow peripheral clock with random high and low times
    initial begin : peripheral_clock_drive
        @(negedge reset);
        while (!stop_peripheral_clock) begin
            repeat ($urandom_range(2, 12)) @(posedge clock);
            if (!peripheral_clock) begin
                rise_count++;
            end
            peripheral_clock <= ~peripheral_clock;
        end
        @(posedge clock);
        peripheral_clock <= 1'b0;
    end

    initial begin : stimulus
        logic [7:0]  value;
        logic [1:0]  bank;
        logic [15:0] port;
        void'($urandom(32'he76b_5982));
        reset                   = 1'b1;
        address                 = '0;
        write_data              = '0;
        io_read_n               = 1'b1;
        io_write_n              = 1'b1;
        memory_read_n           = 1'b1;
        address_enable_n        = 1'b1;
        interrupt_acknowledge_n = 1'b1;
        ems_enabled             = 1'b0;
        ems_address             = 2'd0;
        tandy_video             = 1'b0;
        peripheral_clock        = 1'b0;
        pic_data                = '0;
        pit_data                = '0;
        ppi_data                = '0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        @(negedge clock);
        check_value(read_flag, 1'b0, "read flag after reset");
        check_value(ems_bank_hit, 4'h0, "bank hits after reset");
        check_value(timer_clock, 1'b0, "timer clock after reset");
        check_value({lpt_data, nmi_mask, video_page}, 24'hFFFF00, "control bytes after reset");

        // Decode with random EMS and Tandy gating
        for (int i = 0; i < 600; i++) begin
            drive_cycle(pick_port(), $urandom_range(0, 2), 8'($urandom));
            ems_enabled <= 1'($urandom_range(0, 1));
            tandy_video <= 1'($urandom_range(0, 1));
            if ($urandom_range(0, 7) == 0) begin
                address_enable_n <= 1'b1;
            end
        end

        // EMS writes, each read back two cycles later
        drive_cycle(16'h0000, 0, 8'h00);
        ems_enabled <= 1'b1;
        tandy_video <= 1'b1;
        for (int i = 0; i < 250; i++) begin
            bank = 2'($urandom_range(0, 3));
            case ($urandom_range(0, 2))
                0:       value = 8'hFF;
                1:       value = 8'($urandom_range(0, 8'h7F));
                default: value = 8'($urandom_range(8'h80, 8'hFE));
            endcase
            drive_cycle(16'(EMS_BASE + bank), 2, value);
            drive_cycle(16'h0000, 0, 8'h00);
            drive_cycle(16'(EMS_BASE + bank), 1, 8'h00);
            drive_cycle(16'(EMS_BASE + $urandom_range(0, 3)), 1, 8'h00);
        end

        // Back-to-back bank writes, then memory cycles over the windows
        for (int i = 0; i < 40; i++) begin
            for (int b = 0; b < 4; b++) begin
                drive_cycle(16'(EMS_BASE + b), 2, 8'($urandom_range(0, 8'h7F)));
            end
            drive_cycle(16'(EMS_BASE + $urandom_range(0, 3)), 2, 8'hFF);
            drive_cycle(16'h0000, 0, 8'h00);
            for (int b = 0; b < 4; b++) begin
                drive_cycle(16'(EMS_BASE + b), 1, 8'h00);
            end
            for (int j = 0; j < 10; j++) begin
                @(posedge clock);
                address          <= {4'(4'hA + $urandom_range(0, 3)), 16'($urandom)};
                ems_address      <= 2'($urandom_range(0, 3));
                memory_read_n    <= 1'b0;
                address_enable_n <= 1'($urandom_range(0, 1));
                io_read_n        <= ($urandom_range(0, 7) != 0);
                io_write_n       <= 1'b1;
            end
        end

        // Control bytes
        for (int i = 0; i < 100; i++) begin
            value = 8'($urandom);
            case ($urandom_range(0, 2))
                0:       port = LPT_BASE;
                1:       port = 16'(16'h00A0 + $urandom_range(0, 7));
                default: port = 16'h03DF;
            endcase
            drive_cycle(port, 2, value);
            drive_cycle(port, 1, 8'h00);
        end

        // Overlapping reads under interrupt acknowledge
        for (int i = 0; i < 200; i++) begin
            drive_cycle(pick_port(), ($urandom_range(0, 3) == 0) ? 2 : 1, 8'($urandom));
            interrupt_acknowledge_n <= ($urandom_range(0, 3) != 0);
        end
        drive_cycle(16'h0000, 0, 8'h00);
        interrupt_acknowledge_n <= 1'b1;

        stop_peripheral_clock = 1'b1;
        repeat (40) @(posedge clock);
        check_value(toggle_count, rise_count, "timer clock toggles");
        $display("test passed");
        $finish;
    end

endmodule

// File: design/peripheral_glue_top.sv
/*
 * Peripheral glue top level
 * I/O decode, EMS mapper, control bytes, timer clock and read bus
 */
`timescale 1ns/1ns

module peripheral_glue_top #(
    parameter logic [periph_pkg::IO_PORT_W-1:0] EMS_PORT_BASE =
        periph_pkg::EMS_PORT_BASE_DEFAULT,
    parameter logic [periph_pkg::IO_PORT_W-1:0] LPT_PORT_BASE =
        periph_pkg::LPT_PORT_BASE_DEFAULT
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [periph_pkg::ADDR_W-1:0]    address_i,
    input  logic [periph_pkg::DATA_W-1:0]    data_i,
    input  logic                             io_read_n_i,
    input  logic                             io_write_n_i,
    input  logic                             memory_read_n_i,
    input  logic                             address_enable_n_i,
    input  logic                             interrupt_acknowledge_n_i,
    input  logic                             ems_enabled_i,
    input  logic [1:0]                       ems_address_i,
    input  logic                             tandy_video_i,
    input  logic                             peripheral_clock_i,
    input  logic [periph_pkg::DATA_W-1:0]    pic_data_i,
    input  logic [periph_pkg::DATA_W-1:0]    pit_data_i,
    input  logic [periph_pkg::DATA_W-1:0]    ppi_data_i,
    output logic                             dma_cs_n_o,
    output logic                             dma_page_cs_n_o,
    output logic                             pic_cs_n_o,
    output logic                             pit_cs_n_o,
    output logic                             ppi_cs_n_o,
    output logic [periph_pkg::EMS_BANKS-1:0] ems_bank_hit_o,
    output logic [periph_pkg::DATA_W-1:0]    lpt_data_o,
    output logic [periph_pkg::DATA_W-1:0]    nmi_mask_o,
    output logic [periph_pkg::DATA_W-1:0]    video_page_o,
    output logic                             timer_clock_o,
    output logic [periph_pkg::DATA_W-1:0]    data_bus_out_o,
    output logic                             data_bus_out_from_chipset_o
);
    import periph_pkg::*;

    logic [DATA_W-1:0] ems_read_data;

    cpu_bus_if   cpu_bus ();
    io_select_if io_sel ();

    assign cpu_bus.address          = address_i;
    assign cpu_bus.write_data       = data_i;
    assign cpu_bus.io_read_n        = io_read_n_i;
    assign cpu_bus.io_write_n       = io_write_n_i;
    assign cpu_bus.memory_read_n    = memory_read_n_i;
    assign cpu_bus.address_enable_n = address_enable_n_i;

    io_address_decoder #(
        .EMS_PORT_BASE (EMS_PORT_BASE),
        .LPT_PORT_BASE (LPT_PORT_BASE)
    ) u_io_address_decoder (
        .bus             (cpu_bus.decoder),
        .sel             (io_sel.source),
        .ems_enabled_i   (ems_enabled_i),
        .tandy_video_i   (tandy_video_i),
        .dma_cs_n_o      (dma_cs_n_o),
        .dma_page_cs_n_o (dma_page_cs_n_o),
        .pic_cs_n_o      (pic_cs_n_o),
        .pit_cs_n_o      (pit_cs_n_o),
        .ppi_cs_n_o      (ppi_cs_n_o)
    );

    ems_page_mapper u_ems_page_mapper (
        .clock           (clock),
        .reset           (reset),
        .bus             (cpu_bus.target),
        .sel             (io_sel.sink),
        .ems_address_i   (ems_address_i),
        .ems_bank_hit_o  (ems_bank_hit_o),
        .ems_read_data_o (ems_read_data)
    );

    control_registers u_control_registers (
        .clock        (clock),
        .reset        (reset),
        .bus          (cpu_bus.target),
        .sel          (io_sel.sink),
        .lpt_data_o   (lpt_data_o),
        .nmi_mask_o   (nmi_mask_o),
        .video_page_o (video_page_o)
    );

    timer_clock_divider u_timer_clock_divider (
        .clock              (clock),
        .reset              (reset),
        .peripheral_clock_i (peripheral_clock_i),
        .timer_clock_o      (timer_clock_o)
    );

    read_data_mux u_read_data_mux (
        .clock                       (clock),
        .reset                       (reset),
        .bus                         (cpu_bus.target),
        .sel                         (io_sel.sink),
        .interrupt_acknowledge_n_i   (interrupt_acknowledge_n_i),
        .pic_data_i                  (pic_data_i),
        .pit_data_i                  (pit_data_i),
        .ppi_data_i                  (ppi_data_i),
        .ems_read_data_i             (ems_read_data),
        .lpt_data_i                  (lpt_data_o),
        .nmi_mask_i                  (nmi_mask_o),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

// File: design/read_data_mux.sv
/*
 * Read data multiplexer
 * Registered priority pick of the byte returned to the processor
 */
`timescale 1ns/1ns

module read_data_mux (
    input  logic                          clock,
    input  logic                          reset,
    cpu_bus_if.target                     bus,
    io_select_if.sink                     sel,
    input  logic                          interrupt_acknowledge_n_i,
    input  logic [periph_pkg::DATA_W-1:0] pic_data_i,
    input  logic [periph_pkg::DATA_W-1:0] pit_data_i,
    input  logic [periph_pkg::DATA_W-1:0] ppi_data_i,
    input  logic [periph_pkg::DATA_W-1:0] ems_read_data_i,
    input  logic [periph_pkg::DATA_W-1:0] lpt_data_i,
    input  logic [periph_pkg::DATA_W-1:0] nmi_mask_i,
    output logic [periph_pkg::DATA_W-1:0] data_bus_out_o,
    output logic                          data_bus_out_from_chipset_o
);

    logic io_read;

    assign io_read = ~bus.io_read_n;

    // Interrupt vector fetch wins over any I/O read
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_out_from_chipset_o <= 1'b0;
            data_bus_out_o              <= '0;
        end else if (~interrupt_acknowledge_n_i) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= pic_data_i;
        end else if (io_read && sel.pic_sel) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= pic_data_i;
        end else if (io_read && sel.pit_sel) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= pit_data_i;
        end else if (io_read && sel.ppi_sel) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= ppi_data_i;
        end else if (io_read && sel.ems_sel) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= ems_read_data_i;
        end else if (io_read && sel.lpt_sel) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= lpt_data_i;
        end else if (io_read && sel.nmi_sel) begin
            data_bus_out_from_chipset_o <= 1'b1;
            data_bus_out_o              <= nmi_mask_i;
        end else begin
            // Nothing of ours on the bus
            data_bus_out_from_chipset_o <= 1'b0;
            data_bus_out_o              <= '0;
        end
    end

endmodule

// File: design/timer_clock_divider.sv
/*
 * Timer clock divider
 * Synchronizes the peripheral clock and halves it for the timer
 */
`timescale 1ns/1ns

module timer_clock_divider (
    input  logic clock,
    input  logic reset,
    input  logic peripheral_clock_i,
    output logic timer_clock_o
);

    logic sync_1;
    logic sync_2;
    logic rise;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
        end else begin
            sync_1 <= peripheral_clock_i;
            sync_2 <= sync_1;
        end
    end

    assign rise = sync_1 & ~sync_2;

    // One toggle per peripheral clock rising edge
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            timer_clock_o <= 1'b0;
        end else if (rise) begin
            timer_clock_o <= ~timer_clock_o;
        end
    end

endmodule

// File: design/control_registers.sv
/*
 * Control byte registers
 * Printer latch, NMI mask and Tandy video page
 */
`timescale 1ns/1ns

module control_registers (
    input  logic                          clock,
    input  logic                          reset,
    cpu_bus_if.target                     bus,
    io_select_if.sink                     sel,
    output logic [periph_pkg::DATA_W-1:0] lpt_data_o,
    output logic [periph_pkg::DATA_W-1:0] nmi_mask_o,
    output logic [periph_pkg::DATA_W-1:0] video_page_o
);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_o   <= '1;
            // NMI masked out of reset
            nmi_mask_o   <= '1;
            video_page_o <= '0;
        end else if (~bus.io_write_n) begin
            if (sel.lpt_sel) begin
                lpt_data_o <= bus.write_data;
            end
            if (sel.nmi_sel) begin
                nmi_mask_o <= bus.write_data;
            end
            if (sel.video_page_sel) begin
                video_page_o <= bus.write_data;
            end
        end
    end

endmodule

// File: design/ems_page_mapper.sv
/*
 * EMS page mapper
 * Four bank registers with a two-stage write, readback and window hits
 */
`timescale 1ns/1ns

module ems_page_mapper (
    input  logic                             clock,
    input  logic                             reset,
    cpu_bus_if.target                        bus,
    io_select_if.sink                        sel,
    input  logic [1:0]                       ems_address_i,
    output logic [periph_pkg::EMS_BANKS-1:0] ems_bank_hit_o,
    output logic [periph_pkg::DATA_W-1:0]    ems_read_data_o
);
    import periph_pkg::*;

    localparam int BANK_W   = $clog2(EMS_BANKS);
    localparam int WINDOW_W = 4 + BANK_W;

    logic [EMS_PAGE_W-1:0] bank_page [EMS_BANKS];
    logic [EMS_BANKS-1:0]  bank_enable;

    ems_data_t             write_byte;
    logic [BANK_W-1:0]     reg_index;
    logic                  write_update;
    logic                  pend_valid;
    logic [BANK_W-1:0]     pend_bank;
    logic [EMS_PAGE_W-1:0] pend_page;
    logic                  pend_enable;
    logic [3:0]            window_nibble;
    logic                  io_strobe;

    assign write_byte = bus.write_data;
    assign reg_index  = bus.address[BANK_W-1:0];

    // Bytes 80h..FEh leave the bank alone, so they never reach stage two
    assign write_update = sel.ems_sel & ~bus.io_write_n &
                          ((write_byte.raw == EMS_DISABLE_CODE) | ~write_byte.entry.keep);

    // Stage one
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= write_update;
        end
    end

    always_ff @(posedge clock) begin
        pend_bank <= reg_index;
        if (write_byte.raw == EMS_DISABLE_CODE) begin
            pend_page   <= '1;
            pend_enable <= 1'b0;
        end else begin
            pend_page   <= write_byte.entry.page;
            pend_enable <= 1'b1;
        end
    end

    // Stage two, bank update
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            bank_page   <= '{default: '0};
            bank_enable <= '0;
        end else if (pend_valid) begin
            bank_page[pend_bank]   <= pend_page;
            bank_enable[pend_bank] <= pend_enable;
        end
    end

    // Disabled banks read back as FFh
    assign ems_read_data_o = bank_enable[reg_index] ? DATA_W'(bank_page[reg_index])
                                                    : EMS_DISABLE_CODE;

    // Window base: A0000h, C0000h or D0000h
    always_comb begin
        case (ems_address_i)
            2'd0:    window_nibble = 4'hA;
            2'd1:    window_nibble = 4'hC;
            default: window_nibble = 4'hD;
        endcase
    end

    assign io_strobe = ~bus.io_read_n | ~bus.io_write_n;

    // 16 KB per bank inside the window
    always_comb begin
        for (int k = 0; k < EMS_BANKS; k++) begin
            ems_bank_hit_o[k] = ~io_strobe & bank_enable[k] &
                (bus.address[ADDR_W-1 -: WINDOW_W] == {window_nibble, BANK_W'(k)});
        end
    end

endmodule

// File: design/io_address_decoder.sv
/*
 * I/O address decoder
 * Turns the low I/O map into legacy chip selects and internal selects
 */
`timescale 1ns/1ns

module io_address_decoder #(
    parameter logic [periph_pkg::IO_PORT_W-1:0] EMS_PORT_BASE =
        periph_pkg::EMS_PORT_BASE_DEFAULT,
    parameter logic [periph_pkg::IO_PORT_W-1:0] LPT_PORT_BASE =
        periph_pkg::LPT_PORT_BASE_DEFAULT
) (
    cpu_bus_if.decoder  bus,
    io_select_if.source sel,
    input  logic        ems_enabled_i,
    input  logic        tandy_video_i,
    output logic        dma_cs_n_o,
    output logic        dma_page_cs_n_o,
    output logic        pic_cs_n_o,
    output logic        pit_cs_n_o,
    output logic        ppi_cs_n_o
);
    import periph_pkg::*;

    logic                 io_cycle;
    logic [IO_PORT_W-1:0] port;
    logic [4:0]           slot;

    assign io_cycle = ~bus.address_enable_n & (~bus.io_read_n | ~bus.io_write_n);
    assign port     = bus.address[IO_PORT_W-1:0];

    // Legacy chips sit below 100h, 32 ports per slot
    always_comb begin
        slot = '0;
        if (io_cycle && (bus.address[9:8] == 2'b00)) begin
            case (bus.address[7:5])
                3'd0:    slot[0] = 1'b1;
                3'd1:    slot[1] = 1'b1;
                3'd2:    slot[2] = 1'b1;
                3'd3:    slot[3] = 1'b1;
                3'd4:    slot[4] = 1'b1;
                default: slot    = '0;
            endcase
        end
    end

    assign dma_cs_n_o      = ~slot[0];
    assign pic_cs_n_o      = ~slot[1];
    assign pit_cs_n_o      = ~slot[2];
    assign ppi_cs_n_o      = ~slot[3];
    assign dma_page_cs_n_o = ~slot[4];

    assign sel.pic_sel = slot[1];
    assign sel.pit_sel = slot[2];
    assign sel.ppi_sel = slot[3];

    // Four EMS bank registers
    assign sel.ems_sel = io_cycle & ems_enabled_i &
                         (port[IO_PORT_W-1:2] == EMS_PORT_BASE[IO_PORT_W-1:2]);

    assign sel.lpt_sel = io_cycle & (port == LPT_PORT_BASE);

    // NMI mask only exists on the Tandy map, mirrored over eight ports
    assign sel.nmi_sel = io_cycle & tandy_video_i &
                         (port[IO_PORT_W-1:3] == NMI_MASK_PORT[IO_PORT_W-1:3]);

    assign sel.video_page_sel = io_cycle & (port == VIDEO_PAGE_PORT);

endmodule

// File: design/io_select_if.sv
/*
 * Internal device selects
 * Active-high, qualified with a live I/O cycle by the decoder
 */
`timescale 1ns/1ns

interface io_select_if;

    logic pic_sel;
    logic pit_sel;
    logic ppi_sel;
    logic ems_sel;
    logic lpt_sel;
    logic nmi_sel;
    logic video_page_sel;

    modport source (
        output pic_sel, pit_sel, ppi_sel,
        output ems_sel, lpt_sel, nmi_sel, video_page_sel
    );

    modport sink (
        input pic_sel, pit_sel, ppi_sel,
        input ems_sel, lpt_sel, nmi_sel, video_page_sel
    );

endinterface

// File: design/cpu_bus_if.sv
/*
 * Processor side bus
 * Address, write data and the active-low cycle strobes
 */
`timescale 1ns/1ns

interface cpu_bus_if;
    import periph_pkg::*;

    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] write_data;
    logic              io_read_n;
    logic              io_write_n;
    logic              memory_read_n;
    logic              address_enable_n;

    modport decoder (
        input address,
        input io_read_n,
        input io_write_n,
        input address_enable_n
    );

    // Register blocks, EMS mapper and read mux
    modport target (
        input address,
        input write_data,
        input io_read_n,
        input io_write_n,
        input memory_read_n,
        input address_enable_n
    );

endinterface

// File: design/periph_pkg.sv
/*
 * Peripheral glue shared definitions
 * Bus widths, fixed I/O port bases and the EMS register byte layout
 */
package periph_pkg;

    // Processor bus
    localparam int ADDR_W    = 20;
    localparam int DATA_W    = 8;
    localparam int IO_PORT_W = 16;

    // EMS page mapper geometry
    localparam int EMS_BANKS  = 4;
    localparam int EMS_PAGE_W = 7;

    // Fixed port bases
    localparam logic [IO_PORT_W-1:0] NMI_MASK_PORT   = 16'h00A0;
    localparam logic [IO_PORT_W-1:0] VIDEO_PAGE_PORT = 16'h03DF;

    // Defaults for the port bases set at the top level
    localparam logic [IO_PORT_W-1:0] EMS_PORT_BASE_DEFAULT = 16'h0260;
    localparam logic [IO_PORT_W-1:0] LPT_PORT_BASE_DEFAULT = 16'h0378;

    // Writing this byte turns a bank off
    localparam logic [DATA_W-1:0] EMS_DISABLE_CODE = 8'hFF;

    // Page write with the top bit marking bytes that leave the bank alone
    typedef struct packed {
        logic                  keep;
        logic [EMS_PAGE_W-1:0] page;
    } ems_entry_t;

    typedef union packed {
        logic [DATA_W-1:0] raw;
        ems_entry_t        entry;
    } ems_data_t;

endpackage
